// ==== Makefile ====
# Verilator build and run of the ifetch testbench

VERILATOR ?= verilator
TOP       ?= fetch_stage_tb
FLIST     ?= ifetch.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(BUILD_DIR)

// ==== hw/fetch_addr_sel.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_addr_sel
    import ifetch_pkg::*;
#(
    parameter int PARITY = 0   // 0 even bank, 1 odd bank
) (
    input  wire                    clk,
    input  wire                    reset_i,
    input  wire                    init_i,
    input  wire [VADDR_W-1:0]      init_addr_i,
    input  wire                    resteer_i,
    input  wire [LINE_ADDR_W-1:0]  resteer_line_i,
    input  wire                    branch_i,
    input  wire [LINE_ADDR_W-1:0]  branch_line_i,
    input  wire                    take_i,
    output logic [LINE_ADDR_W-1:0] line_addr_o
);

    fetch_addr_u            init_addr;
    logic [LINE_ADDR_W-1:0] init_line;
    logic [LINE_ADDR_W-1:0] next_line;
    logic                   load;
    logic [LINE_ADDR_W-1:0] line_q;

    assign init_addr = init_addr_i;

    // the bank of matching parity gets the init line itself,
    // the other one starts on the following line
    always_comb begin
        if (init_addr.line.line[0] == PARITY[0]) begin
            init_line = init_addr.line.line;
        end else begin
            init_line = init_addr.line.line + LINE_ADDR_W'(1);
        end
    end

    //////////////////////////////////////////////////
    // redirect priority: init, then resteer, then branch
    always_comb begin
        load      = 1'b1;
        next_line = line_q;
        if (init_i) begin
            next_line = init_line;
        end else if (resteer_i) begin
            next_line = resteer_line_i;
        end else if (branch_i) begin
            next_line = branch_line_i;
        end else if (take_i) begin
            next_line = line_q + LINE_ADDR_W'(2);   // skip the other bank's line
        end else begin
            load = 1'b0;                            // back-pressure, hold
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_q <= LINE_ADDR_W'(PARITY);
        end else if (load) begin
            line_q <= next_line;
        end
    end

    assign line_addr_o = line_q;

endmodule

`default_nettype wire

// ==== hw/fetch_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_stage
    import ifetch_pkg::*;
(
    input  wire                               clk,
    input  wire                               reset_i,
    input  wire                               init_i,
    input  wire [VADDR_W-1:0]                 init_addr_i,
    input  wire                               resteer_i,
    input  wire [LINE_ADDR_W-1:0]             resteer_line_even_i,
    input  wire [LINE_ADDR_W-1:0]             resteer_line_odd_i,
    input  wire                               branch_i,
    input  wire [LINE_ADDR_W-1:0]             branch_line_even_i,
    input  wire [LINE_ADDR_W-1:0]             branch_line_odd_i,
    input  wire                               take_even_i,
    input  wire                               take_odd_i,
    input  wire [TLB_ENTRIES-1:0][VPN_W-1:0]  tlb_vpn_i,
    input  wire [TLB_ENTRIES-1:0][VPN_W-1:0]  tlb_pfn_i,
    input  wire [TLB_ENTRIES-1:0]             tlb_valid_i,
    input  wire [TLB_ENTRIES-1:0]             tlb_present_i,
    input  wire [TLB_ENTRIES-1:0]             tlb_pcd_i,
    output wire [LINE_ADDR_W-1:0]             line_addr_even_o,
    output wire [LINE_ADDR_W-1:0]             line_addr_odd_o,
    output wire [LINE_W-1:0]                  line_even_o,
    output wire [LINE_W-1:0]                  line_odd_o,
    output wire                               line_valid_even_o,
    output wire                               line_valid_odd_o,
    output wire                               tlb_miss_even_o,
    output wire                               tlb_miss_odd_o,
    output wire                               prot_fault_even_o,
    output wire                               prot_fault_odd_o,
    output wire                               mem_req_o,
    output wire [PLINE_W-1:0]                 mem_addr_o,
    input  wire                               mem_ack_i,
    input  wire [LINE_W-1:0]                  mem_data_i
);

    logic [PFN_W-1:0]   pfn_even, pfn_odd;
    logic               fill_req_even, fill_req_odd;
    logic [PLINE_W-1:0] fill_pline_even, fill_pline_odd;
    logic               fill_we_even, fill_we_odd;
    logic [LINE_W-1:0]  fill_data;

    //////////////////////////////////////////////////
    // line address selectors
    // a take only counts while the bank's line is valid
    fetch_addr_sel #(.PARITY(0)) sel_even (
        .clk(clk), .reset_i(reset_i),
        .init_i(init_i), .init_addr_i(init_addr_i),
        .resteer_i(resteer_i), .resteer_line_i(resteer_line_even_i),
        .branch_i(branch_i), .branch_line_i(branch_line_even_i),
        .take_i(take_even_i && line_valid_even_o), .line_addr_o(line_addr_even_o)
    );

    fetch_addr_sel #(.PARITY(1)) sel_odd (
        .clk(clk), .reset_i(reset_i),
        .init_i(init_i), .init_addr_i(init_addr_i),
        .resteer_i(resteer_i), .resteer_line_i(resteer_line_odd_i),
        .branch_i(branch_i), .branch_line_i(branch_line_odd_i),
        .take_i(take_odd_i && line_valid_odd_o), .line_addr_o(line_addr_odd_o)
    );

    // per-bank tlb lookup on the line base address
    itlb tlb_even (
        .vaddr_i({line_addr_even_o, {(VADDR_W - LINE_ADDR_W){1'b0}}}),
        .tlb_vpn_i(tlb_vpn_i), .tlb_pfn_i(tlb_pfn_i), .tlb_valid_i(tlb_valid_i),
        .tlb_present_i(tlb_present_i), .tlb_pcd_i(tlb_pcd_i),
        .pfn_o(pfn_even), .miss_o(tlb_miss_even_o), .prot_fault_o(prot_fault_even_o)
    );

    itlb tlb_odd (
        .vaddr_i({line_addr_odd_o, {(VADDR_W - LINE_ADDR_W){1'b0}}}),
        .tlb_vpn_i(tlb_vpn_i), .tlb_pfn_i(tlb_pfn_i), .tlb_valid_i(tlb_valid_i),
        .tlb_present_i(tlb_present_i), .tlb_pcd_i(tlb_pcd_i),
        .pfn_o(pfn_odd), .miss_o(tlb_miss_odd_o), .prot_fault_o(prot_fault_odd_o)
    );

    //////////////////////////////////////////////////
    // cache banks and the shared fill port
    icache_bank bank_even (
        .clk(clk), .reset_i(reset_i), .line_addr_i(line_addr_even_o), .pfn_i(pfn_even),
        .tlb_miss_i(tlb_miss_even_o), .prot_fault_i(prot_fault_even_o),
        .fill_req_o(fill_req_even), .fill_pline_o(fill_pline_even),
        .fill_we_i(fill_we_even), .fill_data_i(fill_data),
        .line_o(line_even_o), .line_valid_o(line_valid_even_o)
    );

    icache_bank bank_odd (
        .clk(clk), .reset_i(reset_i), .line_addr_i(line_addr_odd_o), .pfn_i(pfn_odd),
        .tlb_miss_i(tlb_miss_odd_o), .prot_fault_i(prot_fault_odd_o),
        .fill_req_o(fill_req_odd), .fill_pline_o(fill_pline_odd),
        .fill_we_i(fill_we_odd), .fill_data_i(fill_data),
        .line_o(line_odd_o), .line_valid_o(line_valid_odd_o)
    );

    line_fill_port fill_port (
        .clk(clk), .reset_i(reset_i),
        .fill_req_even_i(fill_req_even), .fill_pline_even_i(fill_pline_even),
        .fill_req_odd_i(fill_req_odd), .fill_pline_odd_i(fill_pline_odd),
        .fill_we_even_o(fill_we_even), .fill_we_odd_o(fill_we_odd),
        .fill_data_o(fill_data),
        .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o),
        .mem_ack_i(mem_ack_i), .mem_data_i(mem_data_i)
    );

endmodule

`default_nettype wire

// ==== hw/icache_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_bank
    import ifetch_pkg::*;
(
    input  wire                    clk,
    input  wire                    reset_i,
    input  wire [LINE_ADDR_W-1:0]  line_addr_i,
    input  wire [PFN_W-1:0]        pfn_i,
    input  wire                    tlb_miss_i,
    input  wire                    prot_fault_i,
    output logic                   fill_req_o,
    output logic [PLINE_W-1:0]     fill_pline_o,
    input  wire                    fill_we_i,
    input  wire [LINE_W-1:0]       fill_data_i,
    output logic [LINE_W-1:0]      line_o,
    output logic                   line_valid_o
);

    logic [PLINE_W-1:0] pline;
    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag;
    logic               fault;
    logic               hit;
    logic               miss;

    logic [BANK_SETS-1:0] valid_q;
    logic [TAG_W-1:0]     tag_q [BANK_SETS];
    logic [LINE_W-1:0]    data_q [BANK_SETS];

    logic               pend_q;         // fill in flight
    logic [PLINE_W-1:0] pend_pline_q;
    logic [INDEX_W-1:0] fill_index;
    logic [TAG_W-1:0]   fill_tag;

    //////////////////////////////////////////////////
    // physical line from frame plus page offset
    assign pline = {pfn_i, line_addr_i[PLINE_W-PFN_W-1:0]};

    // bit 0 only selects the bank, so it is not part of the index
    assign index = pline[INDEX_W:1];
    assign tag   = pline[PLINE_W-1 -: TAG_W];

    assign fault = tlb_miss_i | prot_fault_i;
    assign hit   = valid_q[index] && (tag_q[index] == tag);
    assign miss  = !hit && !fault;

    assign line_o       = data_q[index];
    assign line_valid_o = hit && !fault;

    //////////////////////////////////////////////////
    // fill request
    // once raised, the request stays on the captured line
    // even if the fetch address moves away meanwhile
    assign fill_req_o   = pend_q || miss;
    assign fill_pline_o = pend_q ? pend_pline_q : pline;

    assign fill_index = pend_pline_q[INDEX_W:1];
    assign fill_tag   = pend_pline_q[PLINE_W-1 -: TAG_W];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pend_q  <= 1'b0;
            valid_q <= '0;
        end else if (fill_we_i) begin
            pend_q              <= 1'b0;
            valid_q[fill_index] <= 1'b1;
        end else if (miss && !pend_q) begin
            pend_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (miss && !pend_q) begin
            pend_pline_q <= pline;          // same value the fill port latches
        end
        if (fill_we_i) begin
            tag_q[fill_index]  <= fill_tag;
            data_q[fill_index] <= fill_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/ifetch_pkg.sv ====
`default_nettype none

package ifetch_pkg;

    //////////////////////////////////////////////////
    // address and data widths
    localparam int VADDR_W     = 32;
    localparam int LINE_ADDR_W = 28;   // 16-byte lines
    localparam int LINE_W      = 128;
    localparam int VPN_W       = 20;   // 4 KB pages
    localparam int PFN_W       = 3;    // only the low frame bits reach the cache
    localparam int PADDR_W     = 15;
    localparam int PLINE_W     = 11;

    // tlb and cache sizes
    localparam int TLB_ENTRIES = 8;
    localparam int BANK_SETS   = 16;
    localparam int INDEX_W     = 4;
    localparam int TAG_W       = 6;    // pline minus index minus parity bit

    // fill port states
    localparam logic [1:0] FILL_IDLE         = 2'd0;
    localparam logic [1:0] FILL_REQ          = 2'd1;
    localparam logic [1:0] FILL_RELEASE      = 2'd2;
    localparam logic [1:0] FILL_WAIT_ACK_LOW = 2'd3;

    //////////////////////////////////////////////////
    // one fetch address, read as page or as line
    typedef union packed {
        struct packed {
            logic [VPN_W-1:0]         vpn;
            logic [VADDR_W-VPN_W-1:0] page_off;
        } page;
        struct packed {
            logic [LINE_ADDR_W-1:0]         line;
            logic [VADDR_W-LINE_ADDR_W-1:0] byte_off;
        } line;
    } fetch_addr_u;

endpackage

`default_nettype wire

// ==== hw/itlb.sv ====
`timescale 1ns/10ps
`default_nettype none

module itlb
    import ifetch_pkg::*;
(
    input  wire [VADDR_W-1:0]                  vaddr_i,
    input  wire [TLB_ENTRIES-1:0][VPN_W-1:0]   tlb_vpn_i,
    input  wire [TLB_ENTRIES-1:0][VPN_W-1:0]   tlb_pfn_i,   // frame fields are page-number wide
    input  wire [TLB_ENTRIES-1:0]              tlb_valid_i,
    input  wire [TLB_ENTRIES-1:0]              tlb_present_i,
    input  wire [TLB_ENTRIES-1:0]              tlb_pcd_i,
    output logic [PFN_W-1:0]                   pfn_o,
    output logic                               miss_o,
    output logic                               prot_fault_o
);

    fetch_addr_u       va;
    logic              hit;
    logic [PFN_W-1:0]  frame;
    logic              pcd;

    assign va = vaddr_i;

    //////////////////////////////////////////////////
    // fully associative compare
    // scan top down so the lowest matching entry is the one kept
    always_comb begin
        hit   = 1'b0;
        frame = '0;
        pcd   = 1'b0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (tlb_valid_i[i] && tlb_present_i[i] && (tlb_vpn_i[i] == va.page.vpn)) begin
                hit   = 1'b1;
                frame = tlb_pfn_i[i][PFN_W-1:0];
                pcd   = tlb_pcd_i[i];
            end
        end
    end

    assign pfn_o  = frame;
    assign miss_o = !hit;

    // instruction fetch from uncacheable mmio space is illegal
    assign prot_fault_o = hit && pcd;

endmodule

`default_nettype wire

// ==== hw/line_fill_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module line_fill_port
    import ifetch_pkg::*;
(
    input  wire                 clk,
    input  wire                 reset_i,
    input  wire                 fill_req_even_i,
    input  wire [PLINE_W-1:0]   fill_pline_even_i,
    input  wire                 fill_req_odd_i,
    input  wire [PLINE_W-1:0]   fill_pline_odd_i,
    output logic                fill_we_even_o,
    output logic                fill_we_odd_o,
    output logic [LINE_W-1:0]   fill_data_o,
    output logic                mem_req_o,
    output logic [PLINE_W-1:0]  mem_addr_o,
    input  wire                 mem_ack_i,
    input  wire [LINE_W-1:0]    mem_data_i
);

    logic [1:0]         state_q;
    logic               sel_odd_q;  // bank being served, or served last
    logic               grant_odd;
    logic [PLINE_W-1:0] addr_q;
    logic [LINE_W-1:0]  data_q;

    // round robin, odd wins a tie only if even went last
    assign grant_odd = fill_req_odd_i && (!fill_req_even_i || !sel_odd_q);

    //////////////////////////////////////////////////
    // four-phase handshake FSM
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q   <= FILL_IDLE;
            sel_odd_q <= 1'b1;          // even first after reset
        end else begin
            case (state_q)
                FILL_IDLE: begin
                    if (fill_req_even_i || fill_req_odd_i) begin
                        state_q   <= FILL_REQ;
                        sel_odd_q <= grant_odd;
                    end
                end
                FILL_REQ: begin
                    if (mem_ack_i) begin
                        state_q <= FILL_RELEASE;
                    end
                end
                FILL_RELEASE: state_q <= FILL_WAIT_ACK_LOW;   // line written, req down
                FILL_WAIT_ACK_LOW: begin
                    if (!mem_ack_i) begin
                        state_q <= FILL_IDLE;
                    end
                end
                default: state_q <= FILL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == FILL_IDLE) begin
            addr_q <= grant_odd ? fill_pline_odd_i : fill_pline_even_i;
        end
        if ((state_q == FILL_REQ) && mem_ack_i) begin
            data_q <= mem_data_i;       // valid while ack is high
        end
    end

    assign mem_req_o  = (state_q == FILL_REQ);
    assign mem_addr_o = addr_q;          // stable for the whole request

    assign fill_data_o    = data_q;
    assign fill_we_even_o = (state_q == FILL_RELEASE) && !sel_odd_q;
    assign fill_we_odd_o  = (state_q == FILL_RELEASE) && sel_odd_q;

endmodule

`default_nettype wire

// ==== ifetch.f ====
hw/ifetch_pkg.sv
hw/fetch_addr_sel.sv
hw/itlb.sv
hw/icache_bank.sv
hw/line_fill_port.sv
hw/fetch_stage.sv
tests/fetch_mem_model.sv
tests/fetch_stage_tb.sv

// ==== tests/fetch_mem_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_mem_model
    import ifetch_pkg::*;
(
    input  wire                clk,
    input  wire                reset_i,
    input  wire                mem_req_i,
    input  wire [PLINE_W-1:0]  mem_addr_i,
    output logic               mem_ack_o,
    output logic [LINE_W-1:0]  mem_data_o,
    output int                 req_count_o
);

    integer seed;
    int     delay;

    // word k of physical line p holds p*4+k
    function automatic logic [LINE_W-1:0] line_contents(input logic [PLINE_W-1:0] p);
        logic [LINE_W-1:0] d;
        d = '0;
        for (int k = 0; k < 4; k++) begin
            d[k*32 +: 32] = 32'(p) * 32'd4 + 32'(k);
        end
        return d;
    endfunction

    //////////////////////////////////////////////////
    // four-phase responder
    initial begin
        seed        = 66;
        mem_ack_o   = 1'b0;
        mem_data_o  = '0;
        req_count_o = 0;
        forever begin
            @(posedge clk);
            #1;
            if (!reset_i && mem_req_i) begin
                req_count_o = req_count_o + 1;
                delay = ($unsigned($random(seed)) % 4) + 1;   // 1 to 4 cycles
                repeat (delay - 1) @(posedge clk);
                #1;
                mem_data_o = line_contents(mem_addr_i);
                mem_ack_o  = 1'b1;
                // hold ack until the port drops req
                forever begin
                    @(posedge clk);
                    #1;
                    if (!mem_req_i) break;
                end
                mem_ack_o = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/fetch_stage_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_stage_tb
    import ifetch_pkg::*;
;

    localparam int MAX_ROWS = 8;

    logic clk;
    logic reset_i;
    logic init_i, resteer_i, branch_i;
    logic [VADDR_W-1:0]     init_addr_i;
    logic [LINE_ADDR_W-1:0] resteer_even, resteer_odd, branch_even, branch_odd;
    logic take_even, take_odd;
    logic [TLB_ENTRIES-1:0][VPN_W-1:0] tlb_vpn, tlb_pfn;
    logic [TLB_ENTRIES-1:0] tlb_valid, tlb_present, tlb_pcd;
    wire  [LINE_ADDR_W-1:0] addr_even, addr_odd;
    wire  [LINE_W-1:0]      line_even, line_odd;
    wire  valid_even, valid_odd, miss_even, miss_odd, prot_even, prot_odd;
    wire  mem_req, mem_ack;
    wire  [PLINE_W-1:0] mem_addr;
    wire  [LINE_W-1:0]  mem_data;
    int   req_count;

    // stimulus table, kind is {branch, resteer, init}
    logic [2:0]             t_kind [MAX_ROWS];
    logic [VADDR_W-1:0]     t_init [MAX_ROWS];
    logic [LINE_ADDR_W-1:0] t_re [MAX_ROWS], t_ro [MAX_ROWS], t_be [MAX_ROWS], t_bo [MAX_ROWS];
    int                     t_takes [MAX_ROWS];
    logic [LINE_ADDR_W-1:0] t_exp_e [MAX_ROWS], t_exp_o [MAX_ROWS];
    logic [3:0]             t_fault [MAX_ROWS];   // miss_e, miss_o, prot_e, prot_o
    logic                   t_grow [MAX_ROWS];
    int nrows, errors, checks, cycles, limit, count_before;
    logic [LINE_ADDR_W-1:0] exp_e, exp_o;

    fetch_stage UUT (
        .clk(clk), .reset_i(reset_i), .init_i(init_i), .init_addr_i(init_addr_i),
        .resteer_i(resteer_i), .resteer_line_even_i(resteer_even),
        .resteer_line_odd_i(resteer_odd), .branch_i(branch_i),
        .branch_line_even_i(branch_even), .branch_line_odd_i(branch_odd),
        .take_even_i(take_even), .take_odd_i(take_odd),
        .tlb_vpn_i(tlb_vpn), .tlb_pfn_i(tlb_pfn), .tlb_valid_i(tlb_valid),
        .tlb_present_i(tlb_present), .tlb_pcd_i(tlb_pcd),
        .line_addr_even_o(addr_even), .line_addr_odd_o(addr_odd),
        .line_even_o(line_even), .line_odd_o(line_odd),
        .line_valid_even_o(valid_even), .line_valid_odd_o(valid_odd),
        .tlb_miss_even_o(miss_even), .tlb_miss_odd_o(miss_odd),
        .prot_fault_even_o(prot_even), .prot_fault_odd_o(prot_odd),
        .mem_req_o(mem_req), .mem_addr_o(mem_addr), .mem_ack_i(mem_ack), .mem_data_i(mem_data)
    );

    fetch_mem_model mem (
        .clk(clk), .reset_i(reset_i), .mem_req_i(mem_req), .mem_addr_i(mem_addr),
        .mem_ack_o(mem_ack), .mem_data_o(mem_data), .req_count_o(req_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // reference model of the mapping and memory contents
    function automatic int frame_of(input logic [VPN_W-1:0] vpn);
        case (vpn)
            20'h00010: return 2;
            20'h00020: return 5;
            20'h00030: return 3;
            default:   return -1;
        endcase
    endfunction

    function automatic logic [LINE_W-1:0] expected_line(input logic [LINE_ADDR_W-1:0] la);
        logic [LINE_W-1:0] d;
        int p;
        p = frame_of(la[LINE_ADDR_W-1:8]) * 256 + int'(la[7:0]);
        for (int k = 0; k < 4; k++) begin
            d[k*32 +: 32] = 32'(p * 4 + k);
        end
        return d;
    endfunction

    task automatic compare_value(input string name, input logic [LINE_W-1:0] got,
                                 input logic [LINE_W-1:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic add_row(input logic [2:0] kind, input logic [VADDR_W-1:0] ia,
                           input logic [LINE_ADDR_W-1:0] re, ro, be, bo, input int takes,
                           input logic [LINE_ADDR_W-1:0] ee, eo, input logic [3:0] fault,
                           input logic grow);
        t_kind[nrows] = kind;
        t_init[nrows] = ia;
        t_re[nrows] = re;
        t_ro[nrows] = ro;
        t_be[nrows] = be;
        t_bo[nrows] = bo;
        t_takes[nrows] = takes;
        t_exp_e[nrows] = ee;
        t_exp_o[nrows] = eo;
        t_fault[nrows] = fault;
        t_grow[nrows] = grow;
        nrows++;
    endtask

    task automatic wait_ready();
        while (!((valid_even || miss_even || prot_even) &&
                 (valid_odd || miss_odd || prot_odd))) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_pair(input int r);
        compare_value("line_addr_even_o", 128'(addr_even), 128'(exp_e));
        compare_value("line_addr_odd_o", 128'(addr_odd), 128'(exp_o));
        compare_value("tlb_miss_even_o", 128'(miss_even), 128'(t_fault[r][3]));
        compare_value("tlb_miss_odd_o", 128'(miss_odd), 128'(t_fault[r][2]));
        compare_value("prot_fault_even_o", 128'(prot_even), 128'(t_fault[r][1]));
        compare_value("prot_fault_odd_o", 128'(prot_odd), 128'(t_fault[r][0]));
        compare_value("line_valid_even_o", 128'(valid_even),
                      128'(!(t_fault[r][3] | t_fault[r][1])));
        compare_value("line_valid_odd_o", 128'(valid_odd),
                      128'(!(t_fault[r][2] | t_fault[r][0])));
        if (valid_even) compare_value("line_even_o", line_even, expected_line(exp_e));
        if (valid_odd) compare_value("line_odd_o", line_odd, expected_line(exp_o));
    endtask

    //////////////////////////////////////////////////
    // main sequence
    initial begin
        reset_i = 1'b1;
        {init_i, resteer_i, branch_i, take_even, take_odd} = '0;
        init_addr_i = '0;
        {resteer_even, resteer_odd, branch_even, branch_odd} = '0;
        tlb_vpn = '0;
        tlb_pfn = '0;
        tlb_valid = 8'b0000_0111;
        tlb_present = 8'b0000_0111;
        tlb_pcd = 8'b0000_0100;
        tlb_vpn[0] = 20'h00010;
        tlb_pfn[0] = 20'd2;
        tlb_vpn[1] = 20'h00020;
        tlb_pfn[1] = 20'd5;
        tlb_vpn[2] = 20'h00030;
        tlb_pfn[2] = 20'd3;       // mmio page
        nrows = 0;
        errors = 0;
        checks = 0;
        add_row(3'b001, 32'h0001_0050, 0, 0, 0, 0, 3, 28'h1006, 28'h1005, 4'b0000, 1);
        add_row(3'b001, 32'h0001_0050, 0, 0, 0, 0, 3, 28'h1006, 28'h1005, 4'b0000, 0);
        add_row(3'b111, 32'h0002_0030, 28'h1020, 28'h1021, 28'h1040, 28'h1041, 1,
                28'h2004, 28'h2003, 4'b0000, 1);
        add_row(3'b110, 0, 28'h1010, 28'h1011, 28'h2040, 28'h2041, 1,
                28'h1010, 28'h1011, 4'b0000, 1);
        add_row(3'b010, 0, 28'h5000, 28'h1011, 0, 0, 0, 28'h5000, 28'h1011, 4'b1000, 0);
        add_row(3'b100, 0, 0, 0, 28'h3000, 28'h3001, 0, 28'h3000, 28'h3001, 4'b0011, 0);
        limit = 400 * nrows + 10;

        repeat (4) @(posedge clk);
        #1 reset_i = 1'b0;
        compare_value("line_valid_even_o", 128'(valid_even), 128'(0));
        compare_value("line_valid_odd_o", 128'(valid_odd), 128'(0));
        compare_value("mem_req_o", 128'(mem_req), 128'(0));
        compare_value("line_addr_even_o", 128'(addr_even), 128'(0));
        compare_value("line_addr_odd_o", 128'(addr_odd), 128'(1));

        for (int r = 0; r < nrows; r++) begin
            count_before = req_count;
            init_i = t_kind[r][0];
            resteer_i = t_kind[r][1];
            branch_i = t_kind[r][2];
            init_addr_i = t_init[r];
            {resteer_even, resteer_odd} = {t_re[r], t_ro[r]};
            {branch_even, branch_odd} = {t_be[r], t_bo[r]};
            @(posedge clk);
            #1 {init_i, resteer_i, branch_i} = '0;
            exp_e = t_exp_e[r];
            exp_o = t_exp_o[r];
            wait_ready();
            check_pair(r);
            for (int t = 0; t < t_takes[r]; t++) begin
                take_even = 1'b1;
                take_odd = 1'b1;
                @(posedge clk);
                #1 {take_even, take_odd} = '0;
                exp_e = exp_e + 28'd2;
                exp_o = exp_o + 28'd2;
                wait_ready();
                check_pair(r);
            end
            if (!t_grow[r]) begin
                // a stray fill needs a few cycles to show up at the memory
                repeat (4) @(posedge clk);
                #1;
                checks++;
                assert (req_count == count_before) else begin
                    $display("row %0d issued memory requests although none were due", r);
                    errors++;
                end
            end
        end

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // cycle limit scaled by table length
    initial begin
        cycles = 0;
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles waiting for the fetch lines", cycles);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire
